/* files.f */
hdl/lcd_pkg.sv
hdl/lcd_mode_decode.sv
hdl/lcd_line_buffer.sv
hdl/lcd_scan_timing.sv
hdl/lcd_color_out.sv
hdl/lcd_vga_top.sv
verification/lcd_vga_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the LCD to VGA testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module lcd_vga_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vlcd_vga_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx 'All checks passed'; then
	exit 0
fi
echo "simulation did not pass"
exit 1

/* verification/lcd_vga_tb.sv */
// ------------------------------
// LCD to VGA converter testbench
// cycle model of buffer, scan timing and palette, checked against the DUT
// ------------------------------
`timescale 1ns/100ps

module lcd_vga_tb;

	localparam int H_VISIBLE     = 6;
	localparam int H_FRONT       = 2;
	localparam int H_SYNC        = 3;
	localparam int H_BACK        = 2;
	localparam int V_VISIBLE     = 4;
	localparam int V_FRONT       = 2;
	localparam int V_SYNC        = 1;
	localparam int V_BACK        = 2;
	localparam int V_SYNC_OFFSET = 4;
	localparam int H_TOTAL  = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL  = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
	// worst lcd line is oam, strobes with gaps and hblank
	localparam int LINE_MAX = 2 + 3 * H_VISIBLE + 3;
	// four frames cover the idle and vblank phases, plus 35 lcd lines and spare
	localparam int LIMIT    = 4 * H_TOTAL * V_TOTAL + 40 * LINE_MAX;
	// pointers must also hold the value H_VISIBLE
	localparam int PW       = $clog2(H_VISIBLE + 1);

	typedef logic [PW-1:0] idx_t;

	logic            pclk;
	logic            rst_n;
	logic            clkena;
	lcd_pkg::pixel_t data;
	lcd_pkg::mode_t  mode;
	logic            tint;
	logic            on;
	logic            hs;
	logic            vs;
	lcd_pkg::rgb_t   rgb;

	// ------------------------------
	// reference model state
	// ------------------------------
	lcd_pkg::pixel_t ref_mem [2][H_VISIBLE];
	logic            bank_ok [2];
	idx_t            wp;
	idx_t            rp;
	logic            bank;
	lcd_pkg::mode_t  m_prev;
	logic            ld;
	logic            he;
	logic            ve;
	int              hc;
	int              vc;
	logic            pend;
	logic            e_hs;
	logic            e_vs;
	logic            e_blank;
	lcd_pkg::pixel_t e_shade;
	logic            rd_known;
	lcd_pkg::rgb_t   e_rgb;
	logic            rgb_known;
	int              he_count = 0;

	// checker state
	string           test_name;
	int              errors = 0;
	int              checks = 0;
	int              cycles = 0;
	logic            hs_q = 1'b1;
	int              low_len = 0;
	int              since_fall = 0;
	logic            have_fall = 1'b0;
	int              he_prev = 0;
	int              he_at_fall = 0;
	logic [31:0]     lcg_state = 32'd34781;

	lcd_vga_top #(
		.H_VISIBLE     (H_VISIBLE),
		.H_FRONT       (H_FRONT),
		.H_SYNC        (H_SYNC),
		.H_BACK        (H_BACK),
		.V_VISIBLE     (V_VISIBLE),
		.V_FRONT       (V_FRONT),
		.V_SYNC        (V_SYNC),
		.V_BACK        (V_BACK),
		.V_SYNC_OFFSET (V_SYNC_OFFSET)
	) DUT (.*);

	initial begin
		pclk = 1'b0;
		forever #20 pclk = ~pclk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// colour the output register should take for one pixel
	function automatic lcd_pkg::rgb_t expected_color(input lcd_pkg::pixel_t s,
			input logic blank_in, input logic on_in, input logic tint_in);
		lcd_pkg::pixel_t p;
		lcd_pkg::rgb_t   c;
		p = on_in ? s : lcd_pkg::pixel_t'(0);
		if (blank_in) begin
			c = '0;
		end else if (tint_in) begin
			c = lcd_pkg::TINT_LUT[p];
		end else begin
			c = {3{lcd_pkg::GREY_LUT[p]}};
		end
		return c;
	endfunction

	task automatic check_value(input string name, input logic [17:0] expected,
			input logic [17:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("ERR %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// inputs change just after the rising edge
	task automatic drive_lcd(input logic strobe, input lcd_pkg::pixel_t d,
			input lcd_pkg::mode_t m);
		@(posedge pclk);
		#2;
		clkena = strobe;
		data   = d;
		mode   = m;
	endtask

	// oam, then vram with a full line of strobes, then hblank
	task automatic send_lcd_line();
		int n;
		n = 0;
		repeat (2) drive_lcd(1'b0, '0, lcd_pkg::MODE_OAM);
		while (n < H_VISIBLE) begin
			lcg_state = lcg_next(lcg_state);
			// data still toggles in the idle cycles between strobes
			drive_lcd(lcg_state[20], lcg_state[17:16], lcd_pkg::MODE_VRAM);
			if (lcg_state[20]) begin
				n++;
			end
		end
		repeat (3) drive_lcd(1'b0, '0, lcd_pkg::MODE_HBLANK);
	endtask

	// ------------------------------
	// reference model stepping once per edge
	// ------------------------------
	always @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			hc         = 0;
			vc         = 0;
			pend       = 1'b0;
			wp         = '0;
			rp         = '0;
			bank       = 1'b0;
			bank_ok[0] = 1'b0;
			bank_ok[1] = 1'b0;
			m_prev     = lcd_pkg::MODE_HBLANK;
			e_hs       = 1'b1;
			e_vs       = 1'b0;
			e_blank    = 1'b1;
			e_shade    = '0;
			rd_known   = 1'b1;
			e_rgb      = '0;
			rgb_known  = 1'b1;
		end else begin
			ld = (m_prev == lcd_pkg::MODE_HBLANK) && (mode != lcd_pkg::MODE_HBLANK);
			he = (m_prev == lcd_pkg::MODE_HBLANK) && (mode == lcd_pkg::MODE_OAM);
			ve = (m_prev == lcd_pkg::MODE_VBLANK) && (mode != lcd_pkg::MODE_VBLANK);
			// colour register trails the read by one edge
			e_rgb     = expected_color(e_shade, e_blank, on, tint);
			rgb_known = e_blank || rd_known;
			// picture area reads the bank not being written
			if (hc < H_VISIBLE && vc < V_VISIBLE) begin
				rd_known = bank_ok[!bank] && (int'(rp) < H_VISIBLE);
				if (rd_known) begin
					e_shade = ref_mem[!bank][rp];
				end
				e_blank = 1'b0;
				rp      = rp + idx_t'(1);
			end else begin
				e_blank = 1'b1;
				rp      = '0;
			end
			if (hc == H_VISIBLE + H_FRONT) begin
				e_hs = 1'b0;
			end
			if (hc == H_VISIBLE + H_FRONT + H_SYNC) begin
				e_hs = 1'b1;
			end
			// frame resync waits for the line step
			if (hc == H_TOTAL - 1) begin
				if (vc == V_VISIBLE + V_FRONT) begin
					e_vs = 1'b1;
				end
				if (vc == V_VISIBLE + V_FRONT + V_SYNC) begin
					e_vs = 1'b0;
				end
				vc   = (pend || ve) ? V_TOTAL - V_SYNC_OFFSET : (vc + 1) % V_TOTAL;
				pend = 1'b0;
			end else if (ve) begin
				pend = 1'b1;
			end
			hc = (he || hc == H_TOTAL - 1) ? 0 : hc + 1;
			if (he) begin
				he_count++;
			end
			// a strobe in the toggle cycle still lands in the old bank
			if (clkena && int'(wp) < H_VISIBLE) begin
				ref_mem[bank][wp] = data;
				wp = wp + idx_t'(1);
			end
			if (ld) begin
				bank_ok[bank] = (int'(wp) == H_VISIBLE);
				bank          = ~bank;
				wp            = '0;
			end
			m_prev = mode;
		end
	end

	// ------------------------------
	// checks on the falling edge
	// ------------------------------
	always @(negedge pclk) begin
		cycles++;
		check_value($sformatf("%s hs", test_name), 18'(e_hs), 18'(hs));
		check_value($sformatf("%s vs", test_name), 18'(e_vs), 18'(vs));
		if (rgb_known) begin
			check_value($sformatf("%s rgb", test_name), e_rgb, rgb);
		end
		// pulse shape only over spans without an lcd line start
		if (hs_q && !hs) begin
			if (have_fall && he_count == he_at_fall) begin
				check_value($sformatf("%s hs period", test_name), 18'(H_TOTAL),
					18'(since_fall));
			end
			have_fall  = 1'b1;
			since_fall = 0;
			low_len    = 0;
			he_at_fall = he_prev;
		end
		if (!hs_q && hs && he_count == he_at_fall) begin
			check_value($sformatf("%s hs width", test_name), 18'(H_SYNC), 18'(low_len));
		end
		if (!hs) begin
			low_len++;
		end
		since_fall++;
		hs_q    = hs;
		he_prev = he_count;
		if (cycles > LIMIT) begin
			$display("timeout, run still going after %0d cycles", LIMIT);
			$display("Checks failed");
			$finish;
		end
	end

	initial begin
		rst_n     = 1'b0;
		clkena    = 1'b0;
		data      = '0;
		mode      = lcd_pkg::MODE_HBLANK;
		tint      = 1'b1;
		on        = 1'b1;
		test_name = "reset";
		repeat (3) @(posedge pclk);
		#2;
		rst_n = 1'b1;
		// scan runs free without lcd events
		test_name = "free_run";
		repeat (3 * H_TOTAL) drive_lcd(1'b0, '0, lcd_pkg::MODE_HBLANK);
		test_name = "tint";
		repeat (8) send_lcd_line();
		test_name = "grey";
		tint = 1'b0;
		repeat (8) send_lcd_line();
		test_name = "display_off";
		on = 1'b0;
		repeat (8) send_lcd_line();
		// vblank then lines again from the frame start
		test_name = "vsync";
		on   = 1'b1;
		tint = 1'b1;
		repeat (H_TOTAL) drive_lcd(1'b0, '0, lcd_pkg::MODE_VBLANK);
		repeat (V_TOTAL + 2) send_lcd_line();
		repeat (2 * H_TOTAL) drive_lcd(1'b0, '0, lcd_pkg::MODE_HBLANK);
		$display("errors %0d, checks %0d", errors, checks);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* hdl/lcd_vga_top.sv */
// ------------------------------
// LCD to VGA scan converter top
// mode decode, line buffer, scan timing and colour output
// ------------------------------
`timescale 1ns/100ps

module lcd_vga_top #(
	parameter int H_VISIBLE     = 160,
	parameter int H_FRONT       = 24,
	parameter int H_SYNC        = 20,
	parameter int H_BACK        = 24,
	parameter int V_VISIBLE     = 576,
	parameter int V_FRONT       = 2,
	parameter int V_SYNC        = 2,
	parameter int V_BACK        = 36,
	parameter int V_SYNC_OFFSET = 4
) (
	input  logic            pclk,
	input  logic            rst_n,
	// lcd side
	input  logic            clkena,
	input  lcd_pkg::pixel_t data,
	input  lcd_pkg::mode_t  mode,
	input  logic            tint,
	input  logic            on,
	// vga side
	output logic            hs,
	output logic            vs,
	output lcd_pkg::rgb_t   rgb
);

	lcd_pkg::mode_events_t events;
	lcd_pkg::pixel_t       shade;
	logic                  visible;
	logic                  blank;

	lcd_mode_decode u_decode (
		.pclk   (pclk),
		.rst_n  (rst_n),
		.mode   (mode),
		.events (events)
	);

	lcd_line_buffer #(
		.H_VISIBLE (H_VISIBLE)
	) u_buffer (
		.pclk      (pclk),
		.rst_n     (rst_n),
		.clkena    (clkena),
		.data      (data),
		.line_done (events.line_done),
		.visible   (visible),
		.shade     (shade),
		.blank     (blank)
	);

	lcd_scan_timing #(
		.H_VISIBLE     (H_VISIBLE),
		.H_FRONT       (H_FRONT),
		.H_SYNC        (H_SYNC),
		.H_BACK        (H_BACK),
		.V_VISIBLE     (V_VISIBLE),
		.V_FRONT       (V_FRONT),
		.V_SYNC        (V_SYNC),
		.V_BACK        (V_BACK),
		.V_SYNC_OFFSET (V_SYNC_OFFSET)
	) u_timing (
		.pclk       (pclk),
		.rst_n      (rst_n),
		.hblank_end (events.hblank_end),
		.vblank_end (events.vblank_end),
		.hs         (hs),
		.vs         (vs),
		.visible    (visible)
	);

	lcd_color_out u_color (
		.pclk  (pclk),
		.rst_n (rst_n),
		.shade (shade),
		.blank (blank),
		.on    (on),
		.tint  (tint),
		.rgb   (rgb)
	);

endmodule

/* hdl/lcd_color_out.sv */
// ------------------------------
// colour output stage
// shade to rgb through grey or tint palette, registered
// ------------------------------
`timescale 1ns/100ps

module lcd_color_out (
	input  logic            pclk,
	input  logic            rst_n,
	input  lcd_pkg::pixel_t shade,
	input  logic            blank,
	input  logic            on,
	input  logic            tint,
	output lcd_pkg::rgb_t   rgb
);

	// shade after display enable
	lcd_pkg::pixel_t pix;
	lcd_pkg::chan_t  grey;
	lcd_pkg::rgb_t   color;

	// ------------------------------
	// palette lookup
	// ------------------------------
	always_comb begin
		// display off shows the lightest shade
		pix  = on ? shade : lcd_pkg::pixel_t'(0);
		grey = lcd_pkg::GREY_LUT[pix];
		if (blank) begin
			color = '0;
		end else if (tint) begin
			color = lcd_pkg::TINT_LUT[pix];
		end else begin
			// same level on all channels
			color.r = grey;
			color.g = grey;
			color.b = grey;
		end
	end

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			rgb <= '0;
		end else begin
			rgb <= color;
		end
	end

endmodule

/* hdl/lcd_scan_timing.sv */
// ------------------------------
// VGA scan generator
// free running counters, pulled into phase by lcd events
// ------------------------------
`timescale 1ns/100ps

module lcd_scan_timing #(
	parameter int H_VISIBLE     = 160,
	parameter int H_FRONT       = 24,
	parameter int H_SYNC        = 20,
	parameter int H_BACK        = 24,
	parameter int V_VISIBLE     = 576,
	parameter int V_FRONT       = 2,
	parameter int V_SYNC        = 2,
	parameter int V_BACK        = 36,
	parameter int V_SYNC_OFFSET = 4
) (
	input  logic pclk,
	input  logic rst_n,
	input  logic hblank_end,
	input  logic vblank_end,
	output logic hs,
	output logic vs,
	output logic visible
);

	localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

	typedef logic [$clog2(H_TOTAL)-1:0] hcount_t;
	typedef logic [$clog2(V_TOTAL)-1:0] vcount_t;

	hcount_t h_cnt;
	vcount_t v_cnt;
	logic    h_last;
	// vblank end seen, waiting for the line step
	logic    vblank_pend;

	assign h_last = (h_cnt == hcount_t'(H_TOTAL - 1));

	// ------------------------------
	// horizontal
	// ------------------------------
	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			h_cnt <= '0;
			hs    <= 1'b1;
		end else begin
			// lcd line start wins over the wrap
			if (hblank_end || h_last) begin
				h_cnt <= '0;
			end else begin
				h_cnt <= h_cnt + hcount_t'(1);
			end
			// negative sync pulse
			if (h_cnt == hcount_t'(H_VISIBLE + H_FRONT)) begin
				hs <= 1'b0;
			end
			if (h_cnt == hcount_t'(H_VISIBLE + H_FRONT + H_SYNC)) begin
				hs <= 1'b1;
			end
		end
	end

	// ------------------------------
	// vertical, steps once per line
	// ------------------------------
	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			v_cnt       <= '0;
			vs          <= 1'b0;
			vblank_pend <= 1'b0;
		end else if (h_last) begin
			vblank_pend <= 1'b0;
			// offset leaves room for the lines still in flight
			if (vblank_pend || vblank_end) begin
				v_cnt <= vcount_t'(V_TOTAL - V_SYNC_OFFSET);
			end else if (v_cnt == vcount_t'(V_TOTAL - 1)) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + vcount_t'(1);
			end
			// positive sync pulse
			if (v_cnt == vcount_t'(V_VISIBLE + V_FRONT)) begin
				vs <= 1'b1;
			end
			if (v_cnt == vcount_t'(V_VISIBLE + V_FRONT + V_SYNC)) begin
				vs <= 1'b0;
			end
		end else if (vblank_end) begin
			vblank_pend <= 1'b1;
		end
	end

	// active picture area
	assign visible = (h_cnt < hcount_t'(H_VISIBLE)) && (v_cnt < vcount_t'(V_VISIBLE));

endmodule

/* hdl/lcd_line_buffer.sv */
// ------------------------------
// ping-pong line buffer
// one bank fills from the lcd while the other is read out
// ------------------------------
`timescale 1ns/100ps

module lcd_line_buffer #(
	parameter int H_VISIBLE = 160
) (
	input  logic            pclk,
	input  logic            rst_n,
	input  logic            clkena,
	input  lcd_pkg::pixel_t data,
	input  logic            line_done,
	input  logic            visible,
	output lcd_pkg::pixel_t shade,
	output logic            blank
);

	// pointer must also hold the value H_VISIBLE
	localparam int PTR_W = $clog2(H_VISIBLE + 1);

	typedef logic [PTR_W-1:0] ptr_t;

	// two lines of shades, first index is the bank
	lcd_pkg::pixel_t mem [2][H_VISIBLE];

	ptr_t wptr;
	ptr_t rptr;
	logic wbank;
	logic wr_en;

	// strobes past the end of a line are dropped
	assign wr_en = clkena && (wptr < ptr_t'(H_VISIBLE));

	// ------------------------------
	// write side
	// ------------------------------
	always_ff @(posedge pclk) begin
		if (wr_en) begin
			mem[wbank][wptr] <= data;
		end
	end

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			wptr  <= '0;
			wbank <= 1'b0;
		end else if (line_done) begin
			// line complete, swap banks
			wptr  <= '0;
			wbank <= ~wbank;
		end else if (wr_en) begin
			wptr <= wptr + ptr_t'(1);
		end
	end

	// ------------------------------
	// read side, always the other bank
	// ------------------------------
	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			rptr  <= '0;
			blank <= 1'b1;
		end else if (visible) begin
			rptr  <= rptr + ptr_t'(1);
			blank <= 1'b0;
		end else begin
			rptr  <= '0;
			blank <= 1'b1;
		end
	end

	// shade only matters while blank is low
	always_ff @(posedge pclk) begin
		if (visible) begin
			shade <= mem[~wbank][rptr];
		end
	end

endmodule

/* hdl/lcd_mode_decode.sv */
// ------------------------------
// LCD mode decoder
// turns mode code transitions into one cycle event pulses
// ------------------------------
`timescale 1ns/100ps

module lcd_mode_decode (
	input  logic                  pclk,
	input  logic                  rst_n,
	input  lcd_pkg::mode_t        mode,
	output lcd_pkg::mode_events_t events
);

	// mode seen on the previous edge
	lcd_pkg::mode_t mode_q;

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			mode_q <= lcd_pkg::MODE_HBLANK;
		end else begin
			mode_q <= mode;
		end
	end

	// ------------------------------
	// transition pulses
	// ------------------------------
	always_comb begin
		// any exit from hblank closes the lcd line
		events.line_done  = (mode_q == lcd_pkg::MODE_HBLANK) &&
		                    (mode != lcd_pkg::MODE_HBLANK);
		// hblank to oam marks the start of the next lcd line
		events.hblank_end = (mode_q == lcd_pkg::MODE_HBLANK) &&
		                    (mode == lcd_pkg::MODE_OAM);
		// leaving vblank starts a new lcd frame
		events.vblank_end = (mode_q == lcd_pkg::MODE_VBLANK) &&
		                    (mode != lcd_pkg::MODE_VBLANK);
	end

endmodule

/* hdl/lcd_pkg.sv */
// ------------------------------
// LCD to VGA shared types
// shade, channel and mode types, event and colour bundles, palettes
// ------------------------------
package lcd_pkg;

	// lcd shade, 0 is the lightest
	typedef logic [1:0] pixel_t;
	// one vga colour channel
	typedef logic [5:0] chan_t;
	// lcd controller mode
	typedef logic [1:0] mode_t;

	// mode codes as driven by the lcd controller
	localparam mode_t MODE_HBLANK = 2'd0;
	localparam mode_t MODE_VBLANK = 2'd1;
	localparam mode_t MODE_OAM    = 2'd2;
	localparam mode_t MODE_VRAM   = 2'd3;

	typedef struct packed {
		chan_t r;
		chan_t g;
		chan_t b;
	} rgb_t;

	// single cycle pulses from mode transitions
	typedef struct packed {
		// mode leaves hblank
		logic line_done;
		// hblank straight into oam
		logic hblank_end;
		// mode leaves vblank
		logic vblank_end;
	} mode_events_t;

	// grey level per shade
	localparam chan_t GREY_LUT [4] = '{6'd63, 6'd42, 6'd24, 6'd0};

	// yellow-green tint per shade
	localparam rgb_t TINT_LUT [4] = '{
		'{r: 6'b100111, g: 6'b101111, b: 6'b000100},
		'{r: 6'b100000, g: 6'b101000, b: 6'b000010},
		'{r: 6'b001100, g: 6'b011001, b: 6'b001100},
		'{r: 6'b000111, g: 6'b000100, b: 6'b000100}
	};

endpackage
